// ==== compile.f ====
pim_pkg.sv
pim_axil_slave.sv
pim_cmd_decode.sv
pim_sequencer.sv
pim_readback.sv
pim_ctrl_top.sv
tb_pim_ctrl.sv

// ==== pim_axil_slave.sv ====
`timescale 1ns/1ps

module pim_axil_slave (
    input  logic                       clk_i,
    input  logic                       rst_ni,

    input  logic [pim_pkg::ADDR_W-1:0] s_axil_awaddr_i,
    input  logic                       s_axil_awvalid_i,
    output logic                       s_axil_awready_o,
    input  logic [pim_pkg::DATA_W-1:0] s_axil_wdata_i,
    input  logic                       s_axil_wvalid_i,
    output logic                       s_axil_wready_o,
    output logic                       s_axil_bvalid_o,
    output logic [1:0]                 s_axil_bresp_o,
    input  logic                       s_axil_bready_i,

    input  logic [pim_pkg::ADDR_W-1:0] s_axil_araddr_i,
    input  logic                       s_axil_arvalid_i,
    output logic                       s_axil_arready_o,
    output logic                       s_axil_rvalid_o,
    output logic [pim_pkg::DATA_W-1:0] s_axil_rdata_o,
    output logic [1:0]                 s_axil_rresp_o,
    input  logic                       s_axil_rready_i,

    output logic                       wr_req_o,
    output logic [pim_pkg::ADDR_W-1:0] wr_addr_o,
    output logic [pim_pkg::DATA_W-1:0] wr_data_o,
    output logic                       rd_req_o,
    output logic [pim_pkg::ADDR_W-1:0] rd_addr_o,
    input  logic [pim_pkg::DATA_W-1:0] rd_data_i
);

    logic wr_fire;
    logic rd_fire;

    // address and data accepted together and one at a time
    assign wr_fire = s_axil_awvalid_i && s_axil_wvalid_i && !s_axil_bvalid_o;
    assign rd_fire = s_axil_arvalid_i && !s_axil_rvalid_o;

    assign s_axil_awready_o = wr_fire;
    assign s_axil_wready_o  = wr_fire;
    assign s_axil_arready_o = rd_fire;
    assign s_axil_bresp_o   = 2'b00;  // OKAY
    assign s_axil_rresp_o   = 2'b00;

    assign wr_req_o  = wr_fire;
    assign wr_addr_o = s_axil_awaddr_i;
    assign wr_data_o = s_axil_wdata_i;
    assign rd_req_o  = rd_fire;
    assign rd_addr_o = s_axil_araddr_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            s_axil_bvalid_o <= 1'b0;
            s_axil_rvalid_o <= 1'b0;
        end else begin
            if (wr_fire) begin
                s_axil_bvalid_o <= 1'b1;
            end else if (s_axil_bready_i) begin
                s_axil_bvalid_o <= 1'b0;
            end
            if (rd_fire) begin
                s_axil_rvalid_o <= 1'b1;
            end else if (s_axil_rready_i) begin
                s_axil_rvalid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_fire) begin
            s_axil_rdata_o <= rd_data_i;  // sampled with the request
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        s_axil_bvalid_o && !s_axil_bready_i |=> s_axil_bvalid_o);

endmodule

// ==== pim_cmd_decode.sv ====
`timescale 1ns/1ps

module pim_cmd_decode #(
    parameter logic [pim_pkg::ADDR_W-1:0] MODE_ADDR   = 32'h4100_0000,
    parameter logic [pim_pkg::ADDR_W-1:0] STATUS_ADDR = 32'h4300_0000
) (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        wr_req_i,
    input  logic [pim_pkg::ADDR_W-1:0]  wr_addr_i,
    input  logic [pim_pkg::DATA_W-1:0]  wr_data_i,
    input  logic                        rd_req_i,
    input  logic [pim_pkg::ADDR_W-1:0]  rd_addr_i,
    input  logic                        done_i,
    output logic                        busy_o,
    output logic [2:0]                  mode_sel_o,
    output logic                        start_o,
    output logic [pim_pkg::ROW_W-1:0]   row_o,
    output logic [pim_pkg::COL_W-1:0]   col_o,
    output logic [pim_pkg::PW_W-1:0]    pulse_width_o,
    output logic [pim_pkg::PC_W-1:0]    pulse_count_o,
    output logic [pim_pkg::DATA_W-1:0]  input_data_o,
    output logic [pim_pkg::RXCNT_W-1:0] data_rx_cnt_o,
    output logic                        in_buf_write_o
);
    import pim_pkg::*;

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_ARMED = 2'd1;
    localparam logic [1:0] ST_MODE  = 2'd2;

    logic [1:0]    state_q;
    logic          cmd_taken_q;  // one command per mode
    logic          status_rd;
    logic          mode_wr;
    logic          code_ok;
    logic          in_window;
    logic          cmd_wr;
    pim_cmd_word_u cmd;

    assign cmd       = wr_data_i;
    assign busy_o    = (state_q == ST_MODE);
    assign status_rd = rd_req_i && (rd_addr_i == STATUS_ADDR) && !busy_o;
    assign mode_wr   = wr_req_i && (wr_addr_i == MODE_ADDR) && (state_q == ST_ARMED);
    assign cmd_wr    = wr_req_i && busy_o && !cmd_taken_q && in_window;

    always_comb begin
        case (wr_data_i[2:0])
            MODE_ERASE, MODE_PROGRAM, MODE_READ, MODE_PARALLEL, MODE_LOAD: code_ok = 1'b1;
            default: code_ok = 1'b0;
        endcase
    end

    always_comb begin
        case (mode_sel_o)
            MODE_ERASE, MODE_PROGRAM, MODE_READ: begin
                in_window = (wr_addr_i[ADDR_W-1:CMD_LSB] == CMD_REGION);
            end
            MODE_PARALLEL: in_window = (wr_addr_i[ADDR_W-1:PAR_LSB] == PAR_REGION);
            default:       in_window = 1'b0;  // load takes no command
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q        <= ST_IDLE;
            mode_sel_o     <= '0;
            cmd_taken_q    <= 1'b0;
            start_o        <= 1'b0;
            in_buf_write_o <= 1'b0;
        end else begin
            start_o        <= 1'b0;
            in_buf_write_o <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (status_rd) begin
                        state_q <= ST_ARMED;
                    end
                end
                ST_ARMED: begin
                    if (mode_wr && code_ok) begin
                        state_q     <= ST_MODE;
                        mode_sel_o  <= wr_data_i[2:0];
                        cmd_taken_q <= (wr_data_i[2:0] == MODE_LOAD);
                        start_o     <= (wr_data_i[2:0] == MODE_LOAD);  // load runs at once
                    end
                end
                ST_MODE: begin
                    if (done_i) begin
                        state_q     <= ST_IDLE;
                        mode_sel_o  <= '0;
                        cmd_taken_q <= 1'b0;
                    end else if (cmd_wr) begin
                        cmd_taken_q    <= 1'b1;
                        start_o        <= 1'b1;
                        in_buf_write_o <= (mode_sel_o == MODE_PARALLEL);
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (cmd_wr) begin
            row_o <= wr_addr_i[ROW_LSB +: ROW_W];
            col_o <= wr_addr_i[COL_W-1:0];
            if (mode_sel_o == MODE_PARALLEL) begin
                input_data_o  <= cmd.data;
                data_rx_cnt_o <= wr_addr_i[RXCNT_LSB +: RXCNT_W];
            end else begin
                pulse_width_o <= cmd.pulse.pulse_width;
                pulse_count_o <= cmd.pulse.pulse_count;
            end
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        start_o |-> busy_o && (mode_sel_o != '0));

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        in_buf_write_o |=> !in_buf_write_o);

endmodule

// ==== pim_ctrl_top.sv ====
`timescale 1ns/1ps

module pim_ctrl_top #(
    parameter logic [pim_pkg::ADDR_W-1:0] MODE_ADDR   = 32'h4100_0000,
    parameter logic [pim_pkg::ADDR_W-1:0] STATUS_ADDR = 32'h4300_0000,
    parameter logic [pim_pkg::ADDR_W-1:0] RESULT_ADDR = 32'h4400_0000
) (
    input  logic                        clk_i,
    input  logic                        rst_ni,

    input  logic [pim_pkg::ADDR_W-1:0]  s_axil_awaddr_i,
    input  logic                        s_axil_awvalid_i,
    output logic                        s_axil_awready_o,
    input  logic [pim_pkg::DATA_W-1:0]  s_axil_wdata_i,
    input  logic                        s_axil_wvalid_i,
    output logic                        s_axil_wready_o,
    output logic                        s_axil_bvalid_o,
    output logic [1:0]                  s_axil_bresp_o,
    input  logic                        s_axil_bready_i,
    input  logic [pim_pkg::ADDR_W-1:0]  s_axil_araddr_i,
    input  logic                        s_axil_arvalid_i,
    output logic                        s_axil_arready_o,
    output logic                        s_axil_rvalid_o,
    output logic [pim_pkg::DATA_W-1:0]  s_axil_rdata_o,
    output logic [1:0]                  s_axil_rresp_o,
    input  logic                        s_axil_rready_i,

    // eFlash row driver
    output logic                        pim_en_o,
    output logic [2:0]                  pim_mode_o,
    output logic [pim_pkg::EXEC_W-1:0]  exec_cnt_o,
    output logic [pim_pkg::ROW_W-1:0]   row_addr_o,
    output logic [pim_pkg::COL_W-1:0]   col_addr_o,

    output logic [pim_pkg::DATA_W-1:0]  input_data_o,
    output logic [pim_pkg::RXCNT_W-1:0] data_rx_cnt_o,
    output logic                        in_buf_write_o,
    output logic                        in_buf_read_o,

    input  logic [pim_pkg::DATA_W-1:0]  out_buf_data_i,
    output logic                        buf_read_en_o,
    output logic                        shift_counter_en_o,
    output logic                        load_en_o,
    output logic [pim_pkg::LOAD_W-1:0]  load_cnt_o
);
    import pim_pkg::*;

    logic              wr_req;
    logic [ADDR_W-1:0] wr_addr;
    logic [DATA_W-1:0] wr_data;
    logic              rd_req;
    logic [ADDR_W-1:0] rd_addr;
    logic [DATA_W-1:0] rd_data;
    logic              busy;
    logic [2:0]        mode_sel;
    logic              start;
    logic              done;
    logic              load_active;
    logic [ROW_W-1:0]  row;
    logic [COL_W-1:0]  col;
    logic [PW_W-1:0]   pulse_width;
    logic [PC_W-1:0]   pulse_count;

    pim_axil_slave u_axil (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .s_axil_awaddr_i  (s_axil_awaddr_i),
        .s_axil_awvalid_i (s_axil_awvalid_i),
        .s_axil_awready_o (s_axil_awready_o),
        .s_axil_wdata_i   (s_axil_wdata_i),
        .s_axil_wvalid_i  (s_axil_wvalid_i),
        .s_axil_wready_o  (s_axil_wready_o),
        .s_axil_bvalid_o  (s_axil_bvalid_o),
        .s_axil_bresp_o   (s_axil_bresp_o),
        .s_axil_bready_i  (s_axil_bready_i),
        .s_axil_araddr_i  (s_axil_araddr_i),
        .s_axil_arvalid_i (s_axil_arvalid_i),
        .s_axil_arready_o (s_axil_arready_o),
        .s_axil_rvalid_o  (s_axil_rvalid_o),
        .s_axil_rdata_o   (s_axil_rdata_o),
        .s_axil_rresp_o   (s_axil_rresp_o),
        .s_axil_rready_i  (s_axil_rready_i),
        .wr_req_o         (wr_req),
        .wr_addr_o        (wr_addr),
        .wr_data_o        (wr_data),
        .rd_req_o         (rd_req),
        .rd_addr_o        (rd_addr),
        .rd_data_i        (rd_data)
    );

    pim_cmd_decode #(
        .MODE_ADDR   (MODE_ADDR),
        .STATUS_ADDR (STATUS_ADDR)
    ) u_decode (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .wr_req_i       (wr_req),
        .wr_addr_i      (wr_addr),
        .wr_data_i      (wr_data),
        .rd_req_i       (rd_req),
        .rd_addr_i      (rd_addr),
        .done_i         (done),
        .busy_o         (busy),
        .mode_sel_o     (mode_sel),
        .start_o        (start),
        .row_o          (row),
        .col_o          (col),
        .pulse_width_o  (pulse_width),
        .pulse_count_o  (pulse_count),
        .input_data_o   (input_data_o),
        .data_rx_cnt_o  (data_rx_cnt_o),
        .in_buf_write_o (in_buf_write_o)
    );

    pim_sequencer u_seq (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .mode_sel_i         (mode_sel),
        .start_i            (start),
        .row_i              (row),
        .col_i              (col),
        .pulse_width_i      (pulse_width),
        .pulse_count_i      (pulse_count),
        .done_o             (done),
        .load_active_o      (load_active),
        .pim_en_o           (pim_en_o),
        .pim_mode_o         (pim_mode_o),
        .exec_cnt_o         (exec_cnt_o),
        .row_addr_o         (row_addr_o),
        .col_addr_o         (col_addr_o),
        .in_buf_read_o      (in_buf_read_o),
        .buf_read_en_o      (buf_read_en_o),
        .shift_counter_en_o (shift_counter_en_o),
        .load_en_o          (load_en_o),
        .load_cnt_o         (load_cnt_o)
    );

    pim_readback #(
        .STATUS_ADDR (STATUS_ADDR),
        .RESULT_ADDR (RESULT_ADDR)
    ) u_readback (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .rd_addr_i      (rd_addr),
        .busy_i         (busy),
        .load_active_i  (load_active),
        .out_buf_data_i (out_buf_data_i),
        .rd_data_o      (rd_data)
    );

endmodule

// ==== pim_pkg.sv ====
package pim_pkg;

    // mode codes on the mode write and on pim_mode_o
    localparam logic [2:0] MODE_ERASE    = 3'd1;
    localparam logic [2:0] MODE_PROGRAM  = 3'd2;
    localparam logic [2:0] MODE_READ     = 3'd3;
    localparam logic [2:0] MODE_PARALLEL = 3'd5;
    localparam logic [2:0] MODE_LOAD     = 3'd7;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // fields of a command-window address
    localparam int ROW_W     = 7;
    localparam int COL_W     = 9;
    localparam int ROW_LSB   = 9;
    localparam int RXCNT_W   = 4;
    localparam int RXCNT_LSB = 16;

    localparam int CMD_LSB = 20;
    localparam int PAR_LSB = 16;
    localparam logic [11:0] CMD_REGION = 12'h400;   // erase, program, read
    localparam logic [15:0] PAR_REGION = 16'h400F;  // parallel

    localparam int PW_W = 17;
    localparam int PC_W = 5;

    localparam int EXEC_W = 4;
    localparam logic [EXEC_W-1:0] READ_CYCLES     = 4'd9;
    localparam logic [EXEC_W-1:0] PARALLEL_CYCLES = 4'd12;

    localparam int LOAD_W = 6;
    localparam logic [LOAD_W-1:0] LOAD_STEPS = 6'd32;

    localparam int OUT_W = 2;
    localparam logic [OUT_W-1:0] OUT_STEPS = 2'd2;

    // command data word as pulse descriptor or input-buffer word
    typedef union packed {
        struct packed {
            logic [9:0]      unused;
            logic [PW_W-1:0] pulse_width;
            logic [PC_W-1:0] pulse_count;
        } pulse;
        logic [DATA_W-1:0] data;
    } pim_cmd_word_u;

endpackage

// ==== pim_readback.sv ====
`timescale 1ns/1ps

module pim_readback #(
    parameter logic [pim_pkg::ADDR_W-1:0] STATUS_ADDR = 32'h4300_0000,
    parameter logic [pim_pkg::ADDR_W-1:0] RESULT_ADDR = 32'h4400_0000
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic [pim_pkg::ADDR_W-1:0] rd_addr_i,
    input  logic                       busy_i,
    input  logic                       load_active_i,
    input  logic [pim_pkg::DATA_W-1:0] out_buf_data_i,
    output logic [pim_pkg::DATA_W-1:0] rd_data_o
);
    import pim_pkg::*;

    logic              load_active_q;
    logic [DATA_W-1:0] result_q;

    // output buffer answers one cycle after each load step
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            load_active_q <= 1'b0;
        end else begin
            load_active_q <= load_active_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_active_q) begin
            result_q <= out_buf_data_i;
        end
    end

    always_comb begin
        if (rd_addr_i == STATUS_ADDR) begin
            rd_data_o = {{(DATA_W-2){1'b0}}, 1'b1, busy_i};  // data-valid always set
        end else if (rd_addr_i == RESULT_ADDR) begin
            rd_data_o = result_q;
        end else begin
            rd_data_o = '0;
        end
    end

endmodule

// ==== pim_sequencer.sv ====
`timescale 1ns/1ps

module pim_sequencer (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic [2:0]                 mode_sel_i,
    input  logic                       start_i,
    input  logic [pim_pkg::ROW_W-1:0]  row_i,
    input  logic [pim_pkg::COL_W-1:0]  col_i,
    input  logic [pim_pkg::PW_W-1:0]   pulse_width_i,
    input  logic [pim_pkg::PC_W-1:0]   pulse_count_i,
    output logic                       done_o,
    output logic                       load_active_o,
    output logic                       pim_en_o,
    output logic [2:0]                 pim_mode_o,
    output logic [pim_pkg::EXEC_W-1:0] exec_cnt_o,
    output logic [pim_pkg::ROW_W-1:0]  row_addr_o,
    output logic [pim_pkg::COL_W-1:0]  col_addr_o,
    output logic                       in_buf_read_o,
    output logic                       buf_read_en_o,
    output logic                       shift_counter_en_o,
    output logic                       load_en_o,
    output logic [pim_pkg::LOAD_W-1:0] load_cnt_o
);
    import pim_pkg::*;

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_EXEC = 2'd1;
    localparam logic [1:0] ST_OUT  = 2'd2;

    logic [1:0]        state_q;
    logic [PW_W-1:0]   pw_q;
    logic [PC_W-1:0]   pc_q;
    logic [EXEC_W-1:0] exec_q;
    logic [LOAD_W-1:0] load_q;
    logic [OUT_W-1:0]  out_q;
    logic              is_pulse;
    logic              is_count;
    logic              is_par;
    logic              exec_end;
    logic              out_end;

    assign is_pulse = (mode_sel_i == MODE_ERASE) || (mode_sel_i == MODE_PROGRAM);
    assign is_par   = (mode_sel_i == MODE_PARALLEL);
    assign is_count = (mode_sel_i == MODE_READ) || is_par;

    always_comb begin
        if (is_pulse) begin
            exec_end = (state_q == ST_EXEC) && (pc_q == '0);
        end else if (is_count) begin
            exec_end = (state_q == ST_EXEC) && (exec_q == '0);
        end else begin
            exec_end = (state_q == ST_EXEC) && (load_q == '0);
        end
    end

    assign out_end = (state_q == ST_OUT) && (out_q == '0);
    assign done_o  = (exec_end && !is_par) || out_end;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= ST_IDLE;
            pw_q    <= '0;
            pc_q    <= '0;
            exec_q  <= '0;
            load_q  <= '0;
            out_q   <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (start_i) begin
                        state_q <= ST_EXEC;
                        pw_q    <= pulse_width_i;
                        pc_q    <= is_pulse ? pulse_count_i : '0;
                        exec_q  <= (mode_sel_i == MODE_READ) ? READ_CYCLES :
                                   is_par ? PARALLEL_CYCLES : '0;
                        load_q  <= (mode_sel_i == MODE_LOAD) ? LOAD_STEPS : '0;
                    end
                end
                ST_EXEC: begin
                    if (exec_end) begin
                        state_q <= is_par ? ST_OUT : ST_IDLE;
                        out_q   <= OUT_STEPS;
                    end else if (is_pulse) begin
                        if (pw_q != '0) begin
                            pw_q <= pw_q - 1'b1;
                        end else begin
                            pw_q <= pulse_width_i;  // low cycle between pulses
                            pc_q <= pc_q - 1'b1;
                        end
                    end else if (is_count) begin
                        exec_q <= exec_q - 1'b1;
                    end else begin
                        load_q <= load_q - 1'b1;
                    end
                end
                ST_OUT: begin
                    if (out_end) begin
                        state_q <= ST_IDLE;
                    end else begin
                        out_q <= out_q - 1'b1;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    assign pim_en_o = (state_q == ST_EXEC) &&
                      ((is_pulse && (pc_q != '0) && (pw_q != '0)) ||
                       (is_count && (exec_q != '0)));
    assign load_en_o = (state_q == ST_EXEC) && (mode_sel_i == MODE_LOAD) && (load_q != '0);

    assign pim_mode_o    = (pim_en_o || load_en_o || state_q == ST_OUT) ? mode_sel_i : '0;
    assign exec_cnt_o    = pim_en_o ? exec_q : '0;
    assign row_addr_o    = pim_en_o ? row_i : '0;
    assign col_addr_o    = pim_en_o ? col_i : '0;
    assign in_buf_read_o = pim_en_o && is_par;

    assign buf_read_en_o      = out_end;
    assign shift_counter_en_o = out_end;

    assign load_cnt_o    = load_en_o ? load_q : '0;
    assign load_active_o = load_en_o;

    assert property (@(posedge clk_i) disable iff (!rst_ni) !(pim_en_o && load_en_o));

endmodule

// ==== tb_pim_ctrl.sv ====
`timescale 1ns/1ps

module tb_pim_ctrl;
    import pim_pkg::*;

    localparam logic [ADDR_W-1:0] MODE_ADDR   = 32'h4100_0000;
    localparam logic [ADDR_W-1:0] STATUS_ADDR = 32'h4300_0000;
    localparam logic [ADDR_W-1:0] RESULT_ADDR = 32'h4400_0000;

    // longest mode is 7 pulses of 16 cycles, plus axi traffic and polling
    localparam int RUN_BUDGET     = 7 * 16 + 60;
    localparam int N_RUNS         = 12;
    localparam int RUN_LIMIT      = 4 * N_RUNS * RUN_BUDGET;
    localparam int TIMEOUT_CYCLES = (RUN_LIMIT > 6000) ? 6000 : RUN_LIMIT;

    logic              clk_i = 1'b0;
    logic              rst_ni = 1'b0;
    logic [ADDR_W-1:0] awaddr = '0;
    logic              awvalid = 1'b0;
    logic [DATA_W-1:0] wdata = '0;
    logic              wvalid = 1'b0;
    logic [ADDR_W-1:0] araddr = '0;
    logic              arvalid = 1'b0;
    logic [DATA_W-1:0] out_buf_data = '0;
    logic              awready, wready, bvalid, arready, rvalid;
    logic [1:0]        bresp, rresp;
    logic [DATA_W-1:0] rdata;
    logic              pim_en_o, in_buf_write_o, in_buf_read_o;
    logic              buf_read_en_o, shift_counter_en_o, load_en_o;
    logic [2:0]        pim_mode_o;
    logic [EXEC_W-1:0] exec_cnt_o;
    logic [ROW_W-1:0]  row_addr_o;
    logic [COL_W-1:0]  col_addr_o;
    logic [DATA_W-1:0] input_data_o;
    logic [RXCNT_W-1:0] data_rx_cnt_o;
    logic [LOAD_W-1:0] load_cnt_o;

    logic [31:0]       seed = 32'h0537_4657;
    int                cycle_cnt = 0;
    int                errors = 0;
    int                checks = 0;
    int                tests = 0;
    int                test_err0 = 0;
    // monitor counters and the values expected while a mode runs
    int                en_high, en_rises, load_high, load_rises, ibr_high, strobes;
    int                ibw_count, attr_err, exp_exec_start;
    logic              en_prev = 1'b0;
    logic              load_prev = 1'b0;
    logic [2:0]        exp_mode;
    logic [ROW_W-1:0]  exp_row;
    logic [COL_W-1:0]  exp_col;
    logic [DATA_W-1:0] ibw_data;
    logic [RXCNT_W-1:0] ibw_rx;
    logic [LOAD_W-1:0] cnt_seen = '0;

    pim_ctrl_top #(
        .MODE_ADDR   (MODE_ADDR),
        .STATUS_ADDR (STATUS_ADDR),
        .RESULT_ADDR (RESULT_ADDR)
    ) dut (
        .clk_i (clk_i), .rst_ni (rst_ni),
        .s_axil_awaddr_i (awaddr), .s_axil_awvalid_i (awvalid), .s_axil_awready_o (awready),
        .s_axil_wdata_i (wdata), .s_axil_wvalid_i (wvalid), .s_axil_wready_o (wready),
        .s_axil_bvalid_o (bvalid), .s_axil_bresp_o (bresp), .s_axil_bready_i (1'b1),
        .s_axil_araddr_i (araddr), .s_axil_arvalid_i (arvalid), .s_axil_arready_o (arready),
        .s_axil_rvalid_o (rvalid), .s_axil_rdata_o (rdata), .s_axil_rresp_o (rresp),
        .s_axil_rready_i (1'b1),
        .pim_en_o (pim_en_o), .pim_mode_o (pim_mode_o), .exec_cnt_o (exec_cnt_o),
        .row_addr_o (row_addr_o), .col_addr_o (col_addr_o),
        .input_data_o (input_data_o), .data_rx_cnt_o (data_rx_cnt_o),
        .in_buf_write_o (in_buf_write_o), .in_buf_read_o (in_buf_read_o),
        .out_buf_data_i (out_buf_data), .buf_read_en_o (buf_read_en_o),
        .shift_counter_en_o (shift_counter_en_o), .load_en_o (load_en_o),
        .load_cnt_o (load_cnt_o)
    );

    always #2 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // output buffer contents for a given load step
    function automatic logic [DATA_W-1:0] out_word(input int cnt);
        return 32'hA5C3_0000 ^ (cnt * 32'h0101_0047);
    endfunction

    // expected values from the command protocol
    function automatic logic [DATA_W-1:0] ref_status(input logic busy);
        return {30'd0, 1'b1, busy};
    endfunction

    function automatic int ref_en_cycles(input logic [2:0] mode, input int w, input int c);
        case (mode)
            MODE_ERASE, MODE_PROGRAM: return w * c;
            MODE_READ:                return 9;
            MODE_PARALLEL:            return 12;
            default:                  return 0;
        endcase
    endfunction

    function automatic int ref_en_pulses(input logic [2:0] mode, input int c);
        case (mode)
            MODE_ERASE, MODE_PROGRAM: return c;
            MODE_READ, MODE_PARALLEL: return 1;
            default:                  return 0;
        endcase
    endfunction

    // output buffer answers one cycle after the load step
    always @(negedge clk_i) cnt_seen <= load_cnt_o;
    always @(posedge clk_i) #1 out_buf_data <= out_word(cnt_seen);

    always @(negedge clk_i) begin
        if (rst_ni) begin
            if (pim_en_o) begin
                if (!en_prev) en_rises++;
                if (pim_mode_o != exp_mode || row_addr_o != exp_row || col_addr_o != exp_col)
                    attr_err++;
                if (exp_exec_start == 0 ? exec_cnt_o != 0 :
                    exec_cnt_o != exp_exec_start - en_high)
                    attr_err++;
                en_high++;
            end
            if (load_en_o) begin
                if (!load_prev) load_rises++;
                if (load_cnt_o != LOAD_STEPS - load_high || pim_mode_o != MODE_LOAD)
                    attr_err++;
                load_high++;
            end
            if (in_buf_read_o) ibr_high++;
            if (buf_read_en_o && shift_counter_en_o) strobes++;
            else if (buf_read_en_o || shift_counter_en_o) attr_err++;  // strobes apart
            if (in_buf_write_o) begin
                ibw_count++;
                ibw_data = input_data_o;
                ibw_rx   = data_rx_cnt_o;
            end
            en_prev   = pim_en_o;
            load_prev = load_en_o;
        end
    end

    task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERR %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (exp != act) begin
            errors++;
            $display("ERR %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic axil_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        @(posedge clk_i) #1;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        do @(negedge clk_i); while (!(awready && wready));
        @(posedge clk_i) #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) @(negedge clk_i);
        if (bresp != 2'b00) begin
            errors++;
            $display("write to %h got a response other than OKAY", addr);
        end
    endtask

    task automatic axil_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        @(posedge clk_i) #1;
        araddr  = addr;
        arvalid = 1'b1;
        do @(negedge clk_i); while (!arready);
        @(posedge clk_i) #1;
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk_i);
        data = rdata;
        if (rresp != 2'b00) begin
            errors++;
            $display("read from %h got a response other than OKAY", addr);
        end
    endtask

    task automatic status_is(input string name, input logic busy);
        logic [DATA_W-1:0] st;
        axil_read(STATUS_ADDR, st);
        check_word(name, ref_status(busy), st);
    endtask

    // poll status until the running mode has ended
    task automatic wait_idle();
        logic [DATA_W-1:0] st;
        do axil_read(STATUS_ADDR, st); while (st[0]);
    endtask

    task automatic begin_test(input logic [2:0] mode, input int exec_start);
        en_high        = 0;
        en_rises       = 0;
        load_high      = 0;
        load_rises     = 0;
        ibr_high       = 0;
        strobes        = 0;
        ibw_count      = 0;
        attr_err       = 0;
        exp_mode       = mode;
        exp_exec_start = exec_start;
        test_err0      = errors;
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_err0) $display("test %s: ok", name);
        else $display("test %s: FAILED with %0d errors", name, errors - test_err0);
    endtask

    task automatic run_pulse(input logic [2:0] mode, input string name);
        int w;
        int c;
        w = (lcg_next() >> 8) % 15 + 1;
        c = (lcg_next() >> 8) % 7 + 1;
        begin_test(mode, 0);
        exp_row = lcg_next() >> 9;
        exp_col = lcg_next() >> 7;
        status_is({name, " status idle"}, 1'b0);
        axil_write(MODE_ADDR, mode);
        axil_write({CMD_REGION, 4'h0, exp_row, exp_col}, (w << PC_W) | c);
        wait_idle();
        check_count({name, " pulses"}, ref_en_pulses(mode, c), en_rises);
        check_count({name, " high cycles"}, ref_en_cycles(mode, w, c), en_high);
        check_count({name, " mode/row/col"}, 0, attr_err);
        end_test(name);
    endtask

    initial begin
        logic [DATA_W-1:0] rd;
        logic [ADDR_W-1:0] addr;
        repeat (10) @(posedge clk_i);
        #1 rst_ni = 1'b1;

        begin_test(3'd0, 0);
        @(negedge clk_i);
        check_word("reset outputs", '0, {awready, wready, bvalid, arready, rvalid,
                   pim_en_o, in_buf_write_o, in_buf_read_o, buf_read_en_o,
                   shift_counter_en_o, load_en_o});
        end_test("reset");

        // mode write with no status read before it
        begin_test(MODE_READ, READ_CYCLES);
        axil_write(MODE_ADDR, MODE_READ);
        axil_write({CMD_REGION, 4'h0, 7'h11, 9'h022}, 32'h0);
        repeat (30) @(posedge clk_i);
        check_count("no_arm activity", 0, en_rises + load_rises + ibw_count);
        status_is("no_arm status", 1'b0);
        end_test("no_arm");

        begin_test(3'd0, 0);
        status_is("status after reset", 1'b0);
        end_test("status");

        for (int i = 0; i < 2; i++) begin
            run_pulse(MODE_ERASE, "erase");
            run_pulse(MODE_PROGRAM, "program");
        end

        // command outside the window, then a good one
        begin_test(MODE_READ, READ_CYCLES);
        exp_row = lcg_next() >> 9;
        exp_col = lcg_next() >> 7;
        status_is("bad_window status idle", 1'b0);
        axil_write(MODE_ADDR, MODE_READ);
        axil_write({12'h500, 4'h0, exp_row, exp_col}, 32'h0);
        repeat (30) @(posedge clk_i);
        check_count("bad_window activity", 0, en_rises);
        status_is("bad_window status busy", 1'b1);
        end_test("bad_window");

        begin_test(MODE_READ, READ_CYCLES);
        axil_write({CMD_REGION, 4'h3, exp_row, exp_col}, 32'h0);
        status_is("read status busy", 1'b1);
        wait_idle();
        check_count("read pulses", ref_en_pulses(MODE_READ, 0), en_rises);
        check_count("read high cycles", ref_en_cycles(MODE_READ, 0, 0), en_high);
        check_count("read mode/row/col/exec", 0, attr_err);
        end_test("read");

        begin_test(MODE_PARALLEL, PARALLEL_CYCLES);
        exp_row = lcg_next() >> 9;
        exp_col = lcg_next() >> 7;
        addr = {PAR_REGION, exp_row, exp_col};
        rd = lcg_next();
        status_is("parallel status idle", 1'b0);
        axil_write(MODE_ADDR, MODE_PARALLEL);
        axil_write(addr, rd);
        wait_idle();
        check_count("parallel in_buf_write", 1, ibw_count);
        check_word("parallel input data", rd, ibw_data);
        check_count("parallel rx count", addr[19:16], ibw_rx);
        check_count("parallel in_buf_read", ref_en_cycles(MODE_PARALLEL, 0, 0), ibr_high);
        check_count("parallel high cycles", ref_en_cycles(MODE_PARALLEL, 0, 0), en_high);
        check_count("parallel strobes", 1, strobes);
        check_count("parallel mode/row/col/exec", 0, attr_err);
        end_test("parallel");

        begin_test(MODE_LOAD, 0);
        status_is("load status idle", 1'b0);
        axil_write(MODE_ADDR, MODE_LOAD);
        wait_idle();
        check_count("load high cycles", LOAD_STEPS, load_high);
        check_count("load pulses", 1, load_rises);
        check_count("load row driver", 0, en_high);
        check_count("load count/mode", 0, attr_err);
        axil_read(RESULT_ADDR, rd);
        check_word("load result", out_word(1), rd);
        end_test("load");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
